/* sha3pad_pkg.sv */
// Shared widths, encodings and helper functions for the SHA-3 padding unit
// Every module of the unit takes what it needs from here by wildcard import

package sha3pad_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned MsgWidth = 64;
  localparam int unsigned MsgStrbW = MsgWidth / 8;

  // The largest block is the SHAKE128 rate of 168 bytes
  localparam int unsigned KeccakMaxWords = 21;
  localparam int unsigned KeccakCountW   = $clog2(KeccakMaxWords + 1);
  localparam int unsigned KeccakAddrW    = KeccakCountW;

  // Encoded N and S as written by software, plus the two bytepad header bytes
  localparam int unsigned NsBytes     = 30;
  localparam int unsigned PrefixBytes = NsBytes + 2;
  localparam int unsigned PrefixWords = PrefixBytes / 8;
  localparam int unsigned PrefixIdxW  = $clog2(PrefixWords);

  typedef logic [MsgWidth-1:0]    msg_word_t;
  typedef logic [MsgStrbW-1:0]    msg_strb_t;
  typedef logic [KeccakAddrW-1:0] keccak_addr_t;
  typedef logic [NsBytes*8-1:0]   ns_data_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    Sha3   = 2'b00,
    Shake  = 2'b01,
    CShake = 2'b10
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } strength_e;

  // Source of the word presented to the Keccak state
  typedef enum logic [2:0] {
    MuxNone    = 3'b000,
    MuxFifo    = 3'b001,
    MuxPrefix  = 3'b010,
    MuxFuncPad = 3'b011,
    MuxZeroEnd = 3'b100
  } pad_mux_e;

  // Block size in 64-bit words, which is the rate divided by the word width
  function automatic keccak_addr_t rate_words(strength_e strength);
    case (strength)
      L128:    return keccak_addr_t'(21);
      L224:    return keccak_addr_t'(18);
      L256:    return keccak_addr_t'(17);
      L384:    return keccak_addr_t'(13);
      L512:    return keccak_addr_t'(9);
      default: return '0;
    endcase
  endfunction

  // Domain suffix with the first bit of pad10*1 already appended at the top
  function automatic logic [4:0] func_suffix(sha3_mode_e mode);
    case (mode)
      Sha3:    return 5'h06;
      Shake:   return 5'h1F;
      CShake:  return 5'h04;
      default: return 5'h01;
    endcase
  endfunction

  // left_encode of the rate in bytes, as used by bytepad in cSHAKE
  function automatic logic [15:0] bytepad_header(strength_e strength);
    logic [7:0] rate_bytes;
    rate_bytes = {rate_words(strength), 3'b000};
    return {rate_bytes, 8'h01};
  endfunction

endpackage

/* pad_ctrl_if.sv */
// Datapath control bundle from the padding FSM to the padding datapath
// The FSM drives every signal through the ctrl modport

`timescale 1ns/1ps

interface pad_ctrl_if
  import sha3pad_pkg::*;
();

  // Which source feeds the Keccak data port
  pad_mux_e sel_mux;
  // FSM-generated words are valid (prefix, suffix and zero fill)
  logic     fsm_valid;
  // Stalls message forwarding while a block is being run
  logic     hold_msg;
  // Capture the partial final word into the buffer
  logic     en_msgbuf;
  logic     clr_msgbuf;

  modport ctrl (
    output sel_mux, fsm_valid, hold_msg, en_msgbuf, clr_msgbuf
  );

  modport dp (
    input sel_mux, fsm_valid, hold_msg, en_msgbuf, clr_msgbuf
  );

endinterface

/* pad_block_counter.sv */
// Counts words written into the current Keccak block
// Supplies the write address and the end-of-block flags used by the FSM

`timescale 1ns/1ps

module pad_block_counter
  import sha3pad_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  strength_e    strength_i,
  input  logic         incr_i,
  input  logic         clr_i,
  output keccak_addr_t addr_o,
  output logic         end_of_block_o,
  output logic         sent_blocksize_o
);

  logic [KeccakCountW-1:0] count_q;
  logic [KeccakCountW-1:0] limit;

  assign limit = rate_words(strength_i);

  // Clear wins over increment so the last acknowledge of a block is dropped
  // when the FSM closes the block in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (incr_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // The word now on the bus is the last one of the block
  assign end_of_block_o   = (KeccakCountW'(count_q + 1'b1) == limit);
  // All words of the block went out
  assign sent_blocksize_o = (count_q == limit);

  // Once full, the address wraps to zero so it never points past the rate
  assign addr_o = (count_q < limit) ? count_q : '0;

  // The FSM has to close every block before a word beyond the rate is taken
  a_count_within_rate: assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_q <= limit
  );

endmodule

/* pad_ctrl_fsm.sv */
// Padding controller for the SHA-3 absorb phase
// Sequences prefix, message forwarding, suffix and zero fill, and starts
// the Keccak permutation once per block

`timescale 1ns/1ps

module pad_ctrl_fsm
  import sha3pad_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  sha3_mode_e mode_i,
  input  logic       start_i,
  input  logic       process_i,
  input  logic       done_i,
  input  logic       msg_valid_i,
  input  logic       msg_partial_i,
  input  logic       keccak_ack_i,
  input  logic       end_of_block_i,
  input  logic       sent_blocksize_i,
  input  logic       keccak_complete_i,
  output logic       keccak_run_o,
  output logic       clr_count_o,
  output logic       absorbed_o,
  pad_ctrl_if.ctrl   ctrl
);

  typedef enum logic [3:0] {
    Idle,
    Prefix,
    PrefixWait,
    Message,
    MessageWait,
    Pad,
    PadRun,
    Pad01,
    PadFlush
  } pad_st_e;

  pad_st_e  st_q, st_d;
  logic     process_q;
  logic     absorbed_d;
  pad_mux_e sel_mux;
  logic     fsm_valid, hold_msg, en_msgbuf, clr_msgbuf;

  ////////////////////////////////////////////////////////////
  // Process latch and registers
  ////////////////////////////////////////////////////////////

  // In cSHAKE the process pulse may arrive while the prefix is still going out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (done_i) begin
      process_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= Idle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    st_d         = st_q;
    keccak_run_o = 1'b0;
    clr_count_o  = 1'b0;
    absorbed_d   = 1'b0;
    sel_mux      = MuxNone;
    fsm_valid    = 1'b0;
    hold_msg     = 1'b0;
    en_msgbuf    = 1'b0;
    clr_msgbuf   = 1'b0;

    case (st_q)
      Idle: begin
        // Only cSHAKE carries the bytepad(N || S) block in front
        if (start_i) begin
          st_d = (mode_i == CShake) ? Prefix : Message;
        end
      end

      Prefix: begin
        sel_mux = MuxPrefix;
        if (sent_blocksize_i) begin
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
          st_d         = PrefixWait;
        end else begin
          fsm_valid = 1'b1;
        end
      end

      PrefixWait: begin
        sel_mux = MuxPrefix;
        if (keccak_complete_i) begin
          st_d = Message;
        end
      end

      Message: begin
        sel_mux = MuxFifo;
        // A partial word is always the last one, keep it for the suffix word
        if (msg_valid_i && msg_partial_i) begin
          en_msgbuf = 1'b1;
        end else if (sent_blocksize_i) begin
          // A full block goes first even when process is already pending
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
          hold_msg     = 1'b1;
          st_d         = MessageWait;
        end else if (process_q || process_i) begin
          hold_msg = 1'b1;
          st_d     = Pad;
        end
      end

      MessageWait: begin
        hold_msg = 1'b1;
        if (keccak_complete_i) begin
          st_d = Message;
        end
      end

      Pad: begin
        // Suffix word, which also carries any buffered message bytes
        sel_mux   = MuxFuncPad;
        fsm_valid = 1'b1;
        if (keccak_ack_i) begin
          clr_msgbuf = 1'b1;
          if (end_of_block_i) begin
            clr_count_o = 1'b1;
            st_d        = PadRun;
          end else begin
            st_d = Pad01;
          end
        end
      end

      PadRun: begin
        keccak_run_o = 1'b1;
        clr_count_o  = 1'b1;
        st_d         = PadFlush;
      end

      Pad01: begin
        // Zero words up to the block end, the last one has bit 63 set
        sel_mux = MuxZeroEnd;
        if (sent_blocksize_i) begin
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
          st_d         = PadFlush;
        end else begin
          fsm_valid = 1'b1;
        end
      end

      PadFlush: begin
        clr_count_o = 1'b1;
        clr_msgbuf  = 1'b1;
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = Idle;
        end
      end

      default: st_d = Idle;
    endcase
  end

  assign ctrl.sel_mux    = sel_mux;
  assign ctrl.fsm_valid  = fsm_valid;
  assign ctrl.hold_msg   = hold_msg;
  assign ctrl.en_msgbuf  = en_msgbuf;
  assign ctrl.clr_msgbuf = clr_msgbuf;

  // Each block runs once and waits for complete, so runs can never be adjacent
  a_run_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) keccak_run_o |=> !keccak_run_o
  );

  a_absorbed_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) absorbed_o |=> !absorbed_o
  );

endmodule

/* pad_datapath.sv */
// Padding datapath between the message FIFO and the Keccak state
// Generates prefix, suffix and zero-fill words and selects the word,
// valid and ready under control of the padding FSM

`timescale 1ns/1ps

module pad_datapath
  import sha3pad_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  sha3_mode_e   mode_i,
  input  strength_e    strength_i,
  input  ns_data_t     ns_data_i,
  input  keccak_addr_t addr_i,
  input  logic         end_of_block_i,
  input  logic         msg_valid_i,
  input  msg_word_t    msg_data_i,
  input  msg_strb_t    msg_strb_i,
  output logic         msg_ready_o,
  output logic         msg_partial_o,
  input  logic         keccak_ready_i,
  output logic         keccak_valid_o,
  output msg_word_t    keccak_data_o,
  output logic         keccak_ack_o,
  pad_ctrl_if.dp       dp
);

  msg_word_t [PrefixWords-1:0] prefix_words;
  msg_word_t                   prefix_data;
  msg_word_t                   suffix_data;
  msg_word_t                   zero_end_data;
  logic [4:0]                  suffix;
  logic [MsgWidth-9:0]         msg_buf;
  logic [MsgStrbW-2:0]         msg_strb;

  // Any word with the top strobe clear is the partial last word
  assign msg_partial_o = ~msg_strb_i[MsgStrbW-1];

  ////////////////////////////////////////////////////////////
  // cSHAKE prefix
  ////////////////////////////////////////////////////////////

  // bytepad header in the two lowest bytes, then the encoded N and S
  assign prefix_words = {ns_data_i, bytepad_header(strength_i)};

  // The prefix is shorter than any block, the rest of the block is zero
  assign prefix_data = (addr_i < keccak_addr_t'(PrefixWords)) ?
                       prefix_words[addr_i[PrefixIdxW-1:0]] : '0;

  ////////////////////////////////////////////////////////////
  // Partial word buffer and suffix merge
  ////////////////////////////////////////////////////////////

  // Byte 7 of a partial word is never valid, so only seven bytes are kept
  always_ff @(posedge clk_i) begin
    if (dp.en_msgbuf) begin
      msg_buf <= msg_data_i[MsgWidth-9:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msg_strb <= '0;
    end else if (dp.en_msgbuf) begin
      msg_strb <= msg_strb_i[MsgStrbW-2:0];
    end else if (dp.clr_msgbuf) begin
      msg_strb <= '0;
    end
  end

  assign suffix = func_suffix(mode_i);

  // Strobes run from byte 0 upwards, so each set strobe pushes the suffix
  // one byte further up
  always_comb begin
    suffix_data        = '0;
    suffix_data[7:0]   = {3'b000, suffix};
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      if (msg_strb[i]) begin
        suffix_data[8*i +: 8]     = msg_buf[8*i +: 8];
        suffix_data[8*(i+1) +: 8] = {3'b000, suffix};
      end
    end
    // Final bit of pad10*1 when the suffix word closes the block
    suffix_data[MsgWidth-1] = suffix_data[MsgWidth-1] | end_of_block_i;
  end

  assign zero_end_data = {end_of_block_i, {(MsgWidth-1){1'b0}}};

  ////////////////////////////////////////////////////////////
  // Output selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dp.sel_mux)
      MuxFifo: begin
        keccak_data_o  = msg_data_i;
        // A buffered partial word is taken here but not forwarded
        keccak_valid_o = msg_valid_i & ~dp.hold_msg & ~dp.en_msgbuf;
        msg_ready_o    = dp.en_msgbuf | (keccak_ready_i & ~dp.hold_msg);
      end
      MuxPrefix: begin
        keccak_data_o  = prefix_data;
        keccak_valid_o = dp.fsm_valid;
        msg_ready_o    = 1'b0;
      end
      MuxFuncPad: begin
        keccak_data_o  = suffix_data;
        keccak_valid_o = dp.fsm_valid;
        msg_ready_o    = 1'b0;
      end
      MuxZeroEnd: begin
        keccak_data_o  = zero_end_data;
        keccak_valid_o = dp.fsm_valid;
        msg_ready_o    = 1'b0;
      end
      default: begin
        keccak_data_o  = '0;
        keccak_valid_o = 1'b0;
        msg_ready_o    = 1'b0;
      end
    endcase
  end

  assign keccak_ack_o = keccak_valid_o & keccak_ready_i;

  // The suffix merge expects the strobes of a buffered word to start at
  // byte 0 and to have no gaps
  a_buffer_strb_contiguous: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dp.en_msgbuf |-> (msg_strb_i & msg_strb_t'(msg_strb_i + 1'b1)) == '0
  );

endmodule

/* sha3pad_top.sv */
// Top level of the SHA-3 padding unit
// Sits between the message FIFO and the Keccak round engine

`timescale 1ns/1ps

module sha3pad_top
  import sha3pad_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         msg_valid_i,
  input  msg_word_t    msg_data_i,
  input  msg_strb_t    msg_strb_i,
  output logic         msg_ready_o,
  input  ns_data_t     ns_data_i,
  output logic         keccak_valid_o,
  output keccak_addr_t keccak_addr_o,
  output msg_word_t    keccak_data_o,
  input  logic         keccak_ready_i,
  output logic         keccak_run_o,
  input  logic         keccak_complete_i,
  input  sha3_mode_e   mode_i,
  input  strength_e    strength_i,
  input  logic         start_i,
  input  logic         process_i,
  input  logic         done_i,
  output logic         absorbed_o
);

  logic end_of_block, sent_blocksize;
  logic keccak_ack, msg_partial, clr_count;

  pad_ctrl_if u_pad_ctrl_if ();

  // Every accepted Keccak word advances the address
  pad_block_counter u_block_counter (
    .clk_i,
    .rst_ni,
    .strength_i,
    .incr_i           (keccak_ack),
    .clr_i            (clr_count),
    .addr_o           (keccak_addr_o),
    .end_of_block_o   (end_of_block),
    .sent_blocksize_o (sent_blocksize)
  );

  pad_ctrl_fsm u_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .mode_i,
    .start_i,
    .process_i,
    .done_i,
    .msg_valid_i,
    .msg_partial_i     (msg_partial),
    .keccak_ack_i      (keccak_ack),
    .end_of_block_i    (end_of_block),
    .sent_blocksize_i  (sent_blocksize),
    .keccak_complete_i,
    .keccak_run_o,
    .clr_count_o       (clr_count),
    .absorbed_o,
    .ctrl              (u_pad_ctrl_if.ctrl)
  );

  pad_datapath u_datapath (
    .clk_i,
    .rst_ni,
    .mode_i,
    .strength_i,
    .ns_data_i,
    .addr_i         (keccak_addr_o),
    .end_of_block_i (end_of_block),
    .msg_valid_i,
    .msg_data_i,
    .msg_strb_i,
    .msg_ready_o,
    .msg_partial_o  (msg_partial),
    .keccak_ready_i,
    .keccak_valid_o,
    .keccak_data_o,
    .keccak_ack_o   (keccak_ack),
    .dp             (u_pad_ctrl_if.dp)
  );

endmodule

/* tb_sha3pad.sv */
// Self-checking testbench for the SHA-3 padding unit
// Models the Keccak engine, drives messages through the padder and compares
// every absorbed block with a byte-level pad10*1 reference model

`timescale 1ns/1ps

module tb_sha3pad
  import sha3pad_pkg::*;
();

  localparam int unsigned MaxBlocks     = 4;
  localparam int unsigned Timeout       = 2000;
  localparam int unsigned CompleteDelay = 24;

  logic         clk_i;
  logic         rst_ni;
  logic         msg_valid_i;
  msg_word_t    msg_data_i;
  msg_strb_t    msg_strb_i;
  logic         msg_ready_o;
  ns_data_t     ns_data_i;
  logic         keccak_valid_o;
  keccak_addr_t keccak_addr_o;
  msg_word_t    keccak_data_o;
  logic         keccak_ready_i;
  logic         keccak_run_o;
  logic         keccak_complete_i;
  sha3_mode_e   mode_i;
  strength_e    strength_i;
  logic         start_i;
  logic         process_i;
  logic         done_i;
  logic         absorbed_o;

  int unsigned  errors;
  int unsigned  compared;
  int unsigned  runs_seen;
  int unsigned  runs_handled;
  int unsigned  absorbed_seen;
  int unsigned  complete_timer;
  int unsigned  exp_blocks;
  int unsigned  cur_rate;
  logic         in_window;
  byte unsigned msg_bytes[$];
  msg_word_t    exp_mem [MaxBlocks][KeccakMaxWords];
  msg_word_t    got_mem [MaxBlocks][KeccakMaxWords];
  logic         got_vld [MaxBlocks][KeccakMaxWords];

  sha3pad_top u_dut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Keccak engine model
  ////////////////////////////////////////////////////////////

  // Outputs are settled by the falling edge, so the state writes are sampled there
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      runs_seen     = 0;
      absorbed_seen = 0;
    end else begin
      if (keccak_valid_o && keccak_ready_i && runs_seen < MaxBlocks &&
          keccak_addr_o < KeccakMaxWords) begin
        got_mem[runs_seen][keccak_addr_o] = keccak_data_o;
        got_vld[runs_seen][keccak_addr_o] = 1'b1;
      end
      if (keccak_run_o) runs_seen++;
      if (absorbed_o) absorbed_seen++;
    end
  end

  // Each run is answered by a complete pulse after the permutation time
  always @(posedge clk_i) begin
    #2;
    keccak_complete_i = 1'b0;
    if (!rst_ni) begin
      complete_timer = 0;
      runs_handled   = 0;
    end else if (runs_handled != runs_seen) begin
      runs_handled   = runs_seen;
      complete_timer = CompleteDelay;
    end else if (complete_timer != 0) begin
      complete_timer--;
      keccak_complete_i = (complete_timer == 0);
    end
    // Random back-pressure, ready three cycles out of four on average
    keccak_ready_i = ($urandom % 4) != 0;
  end

  ////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////

  a_addr_in_rate: assert property (
    @(posedge clk_i) disable iff (!rst_ni) keccak_valid_o |-> keccak_addr_o < cur_rate
  ) else begin
    errors++;
    $display("Keccak word written at address %0d, outside the rate of %0d words",
             $sampled(keccak_addr_o), cur_rate);
  end

  a_ready_in_window: assert property (
    @(posedge clk_i) disable iff (!rst_ni) msg_ready_o |-> in_window
  ) else begin
    errors++;
    $display("Message ready was high outside the start to process window");
  end

  a_absorbed_follows_final: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    keccak_complete_i && runs_seen == exp_blocks |=> absorbed_o
  ) else begin
    errors++;
    $display("Absorbed did not follow the complete of the final block");
  end

  a_absorbed_needs_complete: assert property (
    @(posedge clk_i) disable iff (!rst_ni) absorbed_o |-> $past(keccak_complete_i)
  ) else begin
    errors++;
    $display("Absorbed pulsed without a complete in the cycle before");
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic int unsigned block_words(strength_e strength);
    case (strength)
      L128:    return 21;
      L224:    return 18;
      L256:    return 17;
      L384:    return 13;
      default: return 9;
    endcase
  endfunction

  // Domain bits followed by the first pad bit, least significant bit first
  function automatic byte unsigned suffix_byte(sha3_mode_e mode);
    case (mode)
      Sha3:    return 8'h06;
      Shake:   return 8'h1F;
      default: return 8'h04;
    endcase
  endfunction

  task automatic build_expected(sha3_mode_e mode, strength_e strength, ns_data_t ns);
    byte unsigned stream[$];
    int unsigned  rate_bytes;
    rate_bytes = block_words(strength) * 8;
    // bytepad(N || S) fills a whole block of its own
    if (mode == CShake) begin
      stream.push_back(8'h01);
      stream.push_back(8'(rate_bytes));
      for (int i = 0; i < NsBytes; i++) stream.push_back(ns[8*i +: 8]);
      while (stream.size() % rate_bytes != 0) stream.push_back(8'h00);
    end
    foreach (msg_bytes[i]) stream.push_back(msg_bytes[i]);
    stream.push_back(suffix_byte(mode));
    while (stream.size() % rate_bytes != 0) stream.push_back(8'h00);
    // Closing bit of pad10*1 in the top bit of the last block
    stream[stream.size() - 1] = stream[stream.size() - 1] | 8'h80;
    exp_blocks = stream.size() / rate_bytes;
    for (int i = 0; i < stream.size(); i++) begin
      exp_mem[i / rate_bytes][(i % rate_bytes) / 8][8*(i % 8) +: 8] = stream[i];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!msg_ready_o && !keccak_valid_o && !keccak_run_o && !absorbed_o &&
            keccak_addr_o == '0)
    else begin
      errors++;
      $display("Outputs were not idle after reset");
    end
    @(posedge clk_i);
    #2;
  endtask

  // Called 2 ns after a rising edge and returns at the same point
  task automatic send_word(msg_word_t data, msg_strb_t strb);
    int unsigned waited;
    waited      = 0;
    msg_valid_i = 1'b1;
    msg_data_i  = data;
    msg_strb_i  = strb;
    @(negedge clk_i);
    while (!msg_ready_o && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!msg_ready_o) begin
      errors++;
      $display("Timeout while waiting for the padder to take a message word");
    end
    @(posedge clk_i);
    #2;
    msg_valid_i = 1'b0;
  endtask

  task automatic run_case(string name, sha3_mode_e mode, strength_e strength,
                          int unsigned full_words, int unsigned tail_bytes);
    int unsigned waited;
    msg_word_t   word;
    ns_data_t    ns;
    apply_reset();
    msg_bytes.delete();
    for (int i = 0; i < full_words * 8 + tail_bytes; i++) msg_bytes.push_back(8'($urandom));
    for (int i = 0; i < NsBytes; i++) ns[8*i +: 8] = 8'($urandom);
    foreach (got_vld[b, w]) got_vld[b][w] = 1'b0;
    mode_i     = mode;
    strength_i = strength;
    ns_data_i  = ns;
    cur_rate   = block_words(strength);
    build_expected(mode, strength, ns);

    start_i   = 1'b1;
    in_window = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    for (int w = 0; w < full_words; w++) begin
      for (int k = 0; k < 8; k++) word[8*k +: 8] = msg_bytes[8*w + k];
      send_word(word, 8'hFF);
    end
    // Bytes past the strobes carry junk that must never reach the state
    if (tail_bytes != 0) begin
      word = {$urandom, $urandom};
      for (int k = 0; k < tail_bytes; k++) word[8*k +: 8] = msg_bytes[8*full_words + k];
      send_word(word, msg_strb_t'((1 << tail_bytes) - 1));
    end
    process_i = 1'b1;
    @(posedge clk_i);
    #2;
    process_i = 1'b0;
    in_window = 1'b0;

    waited = 0;
    while (absorbed_seen == 0 && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (absorbed_seen == 0) begin
      errors++;
      $display("%s: timeout while waiting for the absorbed pulse", name);
    end
    // Quiet period so that a second absorbed or run pulse would be seen
    repeat (4) @(posedge clk_i);
    #2;
    done_i = 1'b1;
    @(posedge clk_i);
    #2;
    done_i = 1'b0;

    assert (runs_seen == exp_blocks) else begin
      errors++;
      $display("FAIL %s: run pulses expected %0d actual %0d", name, exp_blocks, runs_seen);
    end
    assert (absorbed_seen == 1) else begin
      errors++;
      $display("FAIL %s: absorbed pulses expected 1 actual %0d", name, absorbed_seen);
    end
    for (int b = 0; b < exp_blocks && b < MaxBlocks; b++) begin
      for (int w = 0; w < cur_rate; w++) begin
        compared++;
        if (!got_vld[b][w]) begin
          errors++;
          $display("%s: block %0d word %0d was never written to the Keccak state", name, b, w);
        end else begin
          assert (got_mem[b][w] == exp_mem[b][w]) else begin
            errors++;
            $display("FAIL %s: block %0d word %0d expected %h actual %h",
                     name, b, w, exp_mem[b][w], got_mem[b][w]);
          end
        end
      end
    end
  endtask

  initial begin
    errors            = 0;
    compared          = 0;
    exp_blocks        = 0;
    cur_rate          = KeccakMaxWords;
    in_window         = 1'b0;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    msg_valid_i       = 1'b0;
    msg_data_i        = '0;
    msg_strb_i        = '0;
    ns_data_i         = '0;
    keccak_ready_i    = 1'b0;
    keccak_complete_i = 1'b0;
    mode_i            = Sha3;
    strength_i        = L256;
    start_i           = 1'b0;
    process_i         = 1'b0;
    done_i            = 1'b0;
    void'($urandom(32'h4477_962f));

    // Two blocks, the suffix lands at address 3 of the second one
    run_case("sha3_256_two_blocks", Sha3, L256, 20, 0);
    run_case("shake128_partial", Shake, L128, 2, 3);
    // Suffix and end bit share the last word of the only block
    run_case("sha3_512_last_word", Sha3, L512, 8, 7);
    run_case("cshake128_prefix", CShake, L128, 3, 5);

    $display("Summary: %0d errors in %0d compared words", errors, compared);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
sha3pad_pkg.sv
pad_ctrl_if.sv
pad_block_counter.sv
pad_ctrl_fsm.sv
pad_datapath.sv
sha3pad_top.sv
tb_sha3pad.sv

/* Bender.yml */
package:
  name: sha3pad

sources:
  - sha3pad_pkg.sv
  - pad_ctrl_if.sv
  - pad_block_counter.sv
  - pad_ctrl_fsm.sv
  - pad_datapath.sv
  - sha3pad_top.sv
  - target: simulation
    files:
      - tb_sha3pad.sv
